// File: all.f
+incdir+hdl
hdl/mul_pkg.sv
hdl/mul_lane_if.sv
hdl/mul_operand_sel.sv
hdl/mul_array.sv
hdl/mul_combine.sv
hdl/mul_unit.sv
tb/tb_mul_unit.sv

// File: hdl/mul_array.sv
////////////////////////////////////////
// multiplier array, three 17x17 signed products
// plus an 8x8 product for the top vector byte
////////////////////////////////////////

`timescale 1ns/10ps
`include "mul_defines.svh"

module mul_array (
  mul_lane_if.array lanes
);

  ////////////////////////////////////////
  // partial-product multipliers
  ////////////////////////////////////////

  // each operand is its sign bit joined to the 16-bit value, so one
  // signed multiplier covers both signed and unsigned halves
  for (genvar i = 0; i < `MUL_N_PP; i++) begin : gen_pp
    logic signed [`MUL_HALF_W:0] mul_a;
    logic signed [`MUL_HALF_W:0] mul_b;

    assign mul_a = $signed({lanes.pp_sign_a[i], lanes.pp_a[i]});
    assign mul_b = $signed({lanes.pp_sign_b[i], lanes.pp_b[i]});

    // full 34-bit signed product
    assign lanes.pp_res[i] = mul_a * mul_b;
  end

  ////////////////////////////////////////
  // top byte multiplier
  ////////////////////////////////////////

  // only the low byte of the product is kept
  assign lanes.byte_res = $signed(lanes.byte_a) * $signed(lanes.byte_b);

endmodule

// File: hdl/mul_combine.sv
////////////////////////////////////////
// product combiner and pass sequencer
// sums the partial products, keeps the MULH accumulator and
// pulses done once the last pass has a valid result
////////////////////////////////////////

`timescale 1ns/10ps
`include "mul_defines.svh"

module mul_combine (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   start_i,
  input  mul_pkg::md_op_e        op_i,
  input  logic                   vec_i,
  input  mul_pkg::vsew_e         vsew_i,
  input  logic                   signed_a_i,
  input  logic                   signed_b_i,
  mul_lane_if.sink               lanes,
  output mul_pkg::mul_phase_e    phase_o,
  output logic                   done_o,
  output logic [`MUL_WORD_W-1:0] result_o
);

  import mul_pkg::*;

  logic                   vec_mode;
  logic                   is_mulh;
  logic                   signed_mult;
  logic                   busy_q;
  mul_phase_e             phase_q;
  logic [`MUL_PP_W-1:0]   acc_q;
  logic [`MUL_PP_W-1:0]   acc_ext;
  logic [`MUL_PP_W-1:0]   summand_0;
  logic [`MUL_PP_W-1:0]   summand_1;
  logic [`MUL_PP_W-1:0]   sum;
  logic [`MUL_WORD_W-1:0] scalar_res;
  mul_word_u              vec_res;

  assign vec_mode    = vec_i && (vsew_i != VSEW_32);
  // every vector request is a single pass
  assign is_mulh     = (op_i == MD_OP_MULH) && !vec_i;
  assign signed_mult = signed_a_i | signed_b_i;

  ////////////////////////////////////////
  // adder
  ////////////////////////////////////////

  // accumulator holds A*B[49:16], shift it down to line up with ah*bh
  assign acc_ext = {{`MUL_HALF_W{signed_mult & acc_q[`MUL_PP_W-1]}},
                    acc_q[`MUL_PP_W-1:`MUL_HALF_W]};

  always_comb begin
    if (phase_q == PHASE_LOW) begin
      // upper half of al*bl plus the two cross products
      summand_0 = {{(`MUL_PP_W-`MUL_HALF_W){1'b0}},
                   lanes.pp_res[0][`MUL_WORD_W-1:`MUL_HALF_W]};
      summand_1 = lanes.pp_res[1];
    end else begin
      summand_0 = '0;
      summand_1 = acc_ext;
    end
  end

  assign sum = summand_0 + summand_1 + lanes.pp_res[2];

  // low word or high word depending on the pass
  assign scalar_res = (phase_q == PHASE_LOW) ?
                      {sum[`MUL_HALF_W-1:0], lanes.pp_res[0][`MUL_HALF_W-1:0]} :
                      sum[`MUL_WORD_W-1:0];

  ////////////////////////////////////////
  // vector packing
  ////////////////////////////////////////

  always_comb begin
    vec_res.word = '0;
    case (vsew_i)
      VSEW_8: begin
        for (int i = 0; i < `MUL_N_PP; i++) begin
          vec_res.bytes[i] = lanes.pp_res[i][`MUL_BYTE_W-1:0];
        end
        vec_res.bytes[`MUL_N_BYTES-1] = lanes.byte_res;
      end
      VSEW_16: begin
        for (int i = 0; i < `MUL_N_HALVES; i++) begin
          vec_res.half[i] = lanes.pp_res[i][`MUL_HALF_W-1:0];
        end
      end
      default: begin
      end
    endcase
  end

  assign result_o = vec_mode ? vec_res.word : scalar_res;

  ////////////////////////////////////////
  // pass sequencing
  ////////////////////////////////////////

  // result is ready in the low pass unless a high pass follows
  assign done_o  = busy_q && ((phase_q == PHASE_HIGH) || !is_mulh);
  assign phase_o = phase_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      phase_q <= PHASE_LOW;
    end else if (start_i) begin
      busy_q  <= 1'b1;
      phase_q <= PHASE_LOW;
    end else if (done_o) begin
      busy_q  <= 1'b0;
      phase_q <= PHASE_LOW;
    end else if (busy_q) begin
      phase_q <= PHASE_HIGH;
    end
  end

  // full low-pass sum, consumed by the high pass
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (busy_q && (phase_q == PHASE_LOW) && is_mulh) begin
      acc_q <= sum;
    end
  end

endmodule

// File: hdl/mul_defines.svh
////////////////////////////////////////
// width macros shared by the multiply unit
// include wherever lane or word widths are needed
////////////////////////////////////////

`ifndef MUL_DEFINES_SVH
`define MUL_DEFINES_SVH

// operand and result word
`define MUL_WORD_W    32
`define MUL_HALF_W    16
`define MUL_BYTE_W    8

// 17x17 signed products and the MULH accumulator
`define MUL_PP_W      34
`define MUL_N_PP      3

// vector lane counts per word
`define MUL_N_BYTES   4
`define MUL_N_HALVES  2

`endif

// File: hdl/mul_lane_if.sv
////////////////////////////////////////
// multiplier lanes between operand selector, array and combiner
// selector drives operands, array drives products
////////////////////////////////////////

`timescale 1ns/10ps
`include "mul_defines.svh"

interface mul_lane_if;

  // 16-bit operands plus the sign bit that extends them to 17 bits
  logic [`MUL_N_PP-1:0][`MUL_HALF_W-1:0] pp_a;
  logic [`MUL_N_PP-1:0][`MUL_HALF_W-1:0] pp_b;
  logic [`MUL_N_PP-1:0]                  pp_sign_a;
  logic [`MUL_N_PP-1:0]                  pp_sign_b;
  // each entry holds a signed 34-bit product
  logic [`MUL_N_PP-1:0][`MUL_PP_W-1:0]   pp_res;

  // top element of an 8-bit vector
  logic [`MUL_BYTE_W-1:0]                byte_a;
  logic [`MUL_BYTE_W-1:0]                byte_b;
  logic [`MUL_BYTE_W-1:0]                byte_res;

  modport sel (output pp_a, pp_b, pp_sign_a, pp_sign_b, byte_a, byte_b);

  modport array (input pp_a, pp_b, pp_sign_a, pp_sign_b, byte_a, byte_b,
                 output pp_res, byte_res);

  modport sink (input pp_res, byte_res);

endinterface

// File: hdl/mul_operand_sel.sv
////////////////////////////////////////
// operand selector for the multiplier array
// scalar passes split the words into halves, vector mode
// routes elements to their own multiplier
////////////////////////////////////////

`timescale 1ns/10ps
`include "mul_defines.svh"

module mul_operand_sel (
  input  mul_pkg::mul_phase_e phase_i,
  input  logic                vec_i,
  input  mul_pkg::vsew_e      vsew_i,
  input  logic                signed_a_i,
  input  logic                signed_b_i,
  input  mul_pkg::mul_word_u  op_a_i,
  input  mul_pkg::mul_word_u  op_b_i,
  mul_lane_if.sel             lanes
);

  import mul_pkg::*;

  logic sign_a;
  logic sign_b;
  logic vec_mode;

  // operand sign only counts for signed operands
  assign sign_a = signed_a_i & op_a_i.word[`MUL_WORD_W-1];
  assign sign_b = signed_b_i & op_b_i.word[`MUL_WORD_W-1];

  // 32-bit elements take the scalar path
  assign vec_mode = vec_i && (vsew_i != VSEW_32);

  // the byte multiplier only matters for 8-bit elements
  assign lanes.byte_a = op_a_i.bytes[`MUL_N_BYTES-1];
  assign lanes.byte_b = op_b_i.bytes[`MUL_N_BYTES-1];

  always_comb begin
    lanes.pp_a      = '0;
    lanes.pp_b      = '0;
    lanes.pp_sign_a = '0;
    lanes.pp_sign_b = '0;

    if (vec_mode) begin
      case (vsew_i)
        VSEW_8: begin
          // low three bytes, sign extended into the 16-bit lanes
          for (int i = 0; i < `MUL_N_PP; i++) begin
            lanes.pp_a[i]      = {{`MUL_BYTE_W{op_a_i.bytes[i][`MUL_BYTE_W-1]}},
                                  op_a_i.bytes[i]};
            lanes.pp_b[i]      = {{`MUL_BYTE_W{op_b_i.bytes[i][`MUL_BYTE_W-1]}},
                                  op_b_i.bytes[i]};
            lanes.pp_sign_a[i] = op_a_i.bytes[i][`MUL_BYTE_W-1];
            lanes.pp_sign_b[i] = op_b_i.bytes[i][`MUL_BYTE_W-1];
          end
        end
        VSEW_16: begin
          // two halves on multipliers one and two, third one idle
          for (int i = 0; i < `MUL_N_HALVES; i++) begin
            lanes.pp_a[i]      = op_a_i.half[i];
            lanes.pp_b[i]      = op_b_i.half[i];
            lanes.pp_sign_a[i] = op_a_i.half[i][`MUL_HALF_W-1];
            lanes.pp_sign_b[i] = op_b_i.half[i][`MUL_HALF_W-1];
          end
        end
        default: begin
        end
      endcase
    end else begin
      // al*bl, always unsigned
      lanes.pp_a[0] = op_a_i.half[0];
      lanes.pp_b[0] = op_b_i.half[0];

      // al*bh
      lanes.pp_a[1]      = op_a_i.half[0];
      lanes.pp_b[1]      = op_b_i.half[1];
      lanes.pp_sign_b[1] = sign_b;

      // ah*bl in the low pass, ah*bh in the high pass
      lanes.pp_a[2]      = op_a_i.half[1];
      lanes.pp_sign_a[2] = sign_a;
      if (phase_i == PHASE_HIGH) begin
        lanes.pp_b[2]      = op_b_i.half[1];
        lanes.pp_sign_b[2] = sign_b;
      end else begin
        lanes.pp_b[2] = op_b_i.half[0];
      end
    end
  end

endmodule

// File: hdl/mul_pkg.sv
////////////////////////////////////////
// types shared by the multiply unit
// operation, element width, pass phase and operand views
////////////////////////////////////////

`include "mul_defines.svh"

package mul_pkg;

  // scalar operation, MULH covers MULHSU and MULHU via the sign bits
  typedef enum logic {
    MD_OP_MULL,
    MD_OP_MULH
  } md_op_e;

  // vector element width, encoding 0/1/2 as in the core
  typedef enum logic [2:0] {
    VSEW_8  = 3'd0,
    VSEW_16 = 3'd1,
    VSEW_32 = 3'd2
  } vsew_e;

  // one operand word seen as scalar halves or as vector elements
  typedef union packed {
    logic [`MUL_WORD_W-1:0]                   word;
    logic [`MUL_N_HALVES-1:0][`MUL_HALF_W-1:0] half;
    logic [`MUL_N_BYTES-1:0][`MUL_BYTE_W-1:0]  bytes;
  } mul_word_u;

  // compute pass, low pass always runs, high pass only for MULH
  typedef enum logic {
    PHASE_LOW,
    PHASE_HIGH
  } mul_phase_e;

endpackage

// File: hdl/mul_unit.sv
////////////////////////////////////////
// multiply unit top with a four-phase req/ack handshake
// hold inputs with req_i high until ack_o, then drop req_i
////////////////////////////////////////

`timescale 1ns/10ps
`include "mul_defines.svh"

module mul_unit (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_i,
  input  mul_pkg::md_op_e        op_i,
  input  logic                   signed_a_i,
  input  logic                   signed_b_i,
  input  logic                   vec_i,
  input  mul_pkg::vsew_e         vsew_i,
  input  logic [`MUL_WORD_W-1:0] op_a_i,
  input  logic [`MUL_WORD_W-1:0] op_b_i,
  output logic                   ack_o,
  output logic [`MUL_WORD_W-1:0] result_o
);

  import mul_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUSY,
    ST_ACK
  } hs_state_e;

  hs_state_e              state_q;
  logic                   accept;
  logic                   comb_done;
  mul_phase_e             phase;
  logic [`MUL_WORD_W-1:0] comb_result;
  logic [`MUL_WORD_W-1:0] result_q;

  // captured request
  md_op_e                 op_q;
  logic                   signed_a_q;
  logic                   signed_b_q;
  logic                   vec_q;
  vsew_e                  vsew_q;
  mul_word_u              op_a_q;
  mul_word_u              op_b_q;

  mul_lane_if lanes ();

  ////////////////////////////////////////
  // handshake
  ////////////////////////////////////////

  // start goes to the combiner in the same cycle as the capture
  assign accept = (state_q == ST_IDLE) && req_i;
  assign ack_o  = (state_q == ST_ACK);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= ST_IDLE;
      result_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (req_i) begin
            state_q <= ST_BUSY;
          end
        end
        ST_BUSY: begin
          if (comb_done) begin
            state_q  <= ST_ACK;
            result_q <= comb_result;
          end
        end
        ST_ACK: begin
          // result held until the requester lets go
          if (!req_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q        <= op_i;
      signed_a_q  <= signed_a_i;
      signed_b_q  <= signed_b_i;
      vec_q       <= vec_i;
      vsew_q      <= vsew_i;
      op_a_q.word <= op_a_i;
      op_b_q.word <= op_b_i;
    end
  end

  assign result_o = result_q;

  ////////////////////////////////////////
  // datapath
  ////////////////////////////////////////

  mul_operand_sel u_operand_sel (
    .phase_i    (phase),
    .vec_i      (vec_q),
    .vsew_i     (vsew_q),
    .signed_a_i (signed_a_q),
    .signed_b_i (signed_b_q),
    .op_a_i     (op_a_q),
    .op_b_i     (op_b_q),
    .lanes      (lanes.sel)
  );

  mul_array u_array (
    .lanes (lanes.array)
  );

  mul_combine u_combine (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (accept),
    .op_i       (op_q),
    .vec_i      (vec_q),
    .vsew_i     (vsew_q),
    .signed_a_i (signed_a_q),
    .signed_b_i (signed_b_q),
    .lanes      (lanes.sink),
    .phase_o    (phase),
    .done_o     (comb_done),
    .result_o   (comb_result)
  );

endmodule

// File: run.sh
#!/bin/sh
# Build and run the multiply unit testbench with Verilator.
# Exit status is non-zero when the build fails or the testbench stops on an error.

cd "$(dirname "$0")" || exit 1

echo "building testbench"
verilator --binary --timing --assert \
  --timescale 1ns/10ps \
  -f all.f \
  --top-module tb_mul_unit \
  -o tb_mul_unit
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit $status
fi

echo "running simulation"
./obj_dir/tb_mul_unit
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0

// File: tb/tb_mul_unit.sv
////////////////////////////////////////
// testbench for the multiply unit
// runs req/ack transactions and checks each result
// against a reference model of the product
////////////////////////////////////////

`timescale 1ns/10ps
`include "mul_defines.svh"

module tb_mul_unit;

  import mul_pkg::*;

  localparam int TIMEOUT_CYCLES = 20;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   req_i;
  md_op_e                 op_i;
  logic                   signed_a_i;
  logic                   signed_b_i;
  logic                   vec_i;
  vsew_e                  vsew_i;
  logic [`MUL_WORD_W-1:0] op_a_i;
  logic [`MUL_WORD_W-1:0] op_b_i;
  logic                   ack_o;
  logic [`MUL_WORD_W-1:0] result_o;

  // shared between stimulus and compare process
  logic [`MUL_WORD_W-1:0] exp_result;
  logic [`MUL_WORD_W-1:0] held_result;
  string                  test_name;
  int                     n_sent;
  int                     n_checked;
  logic                   ack_seen;

  integer                 seed;
  logic [`MUL_WORD_W-1:0] r;
  logic [`MUL_WORD_W-1:0] corners [4];
  md_op_e                 rnd_op;
  vsew_e                  rnd_vsew;

  mul_unit u_mul_unit (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req_i),
    .op_i       (op_i),
    .signed_a_i (signed_a_i),
    .signed_b_i (signed_b_i),
    .vec_i      (vec_i),
    .vsew_i     (vsew_i),
    .op_a_i     (op_a_i),
    .op_b_i     (op_b_i),
    .ack_o      (ack_o),
    .result_o   (result_o)
  );

  always #5 clk_i = ~clk_i;

  ////////////////////////////////////////
  // error reporting and reference model
  ////////////////////////////////////////

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expv,
                                 input logic [31:0] actv);
    stop_on_error($sformatf("CHECK FAILED %s expected %08h actual %08h",
                            name, expv, actv));
  endtask

  // lane products keep the low element bits and scalar MULH keeps the high word
  function automatic logic [31:0] expected_product(input md_op_e op, input logic sa,
                                                   input logic sb, input logic vec,
                                                   input vsew_e vsew,
                                                   input logic [31:0] a,
                                                   input logic [31:0] b);
    logic [31:0] res;
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] prod;
    res = '0;
    ea = sa ? {{32{a[31]}}, a} : {32'b0, a};
    eb = sb ? {{32{b[31]}}, b} : {32'b0, b};
    prod = ea * eb;
    if (vec && vsew == VSEW_8) begin
      for (int i = 0; i < 4; i++) begin
        res[i*8 +: 8] = a[i*8 +: 8] * b[i*8 +: 8];
      end
    end else if (vec && vsew == VSEW_16) begin
      for (int i = 0; i < 2; i++) begin
        res[i*16 +: 16] = a[i*16 +: 16] * b[i*16 +: 16];
      end
    end else if (vec || op == MD_OP_MULL) begin
      res = prod[31:0];
    end else begin
      res = prod[63:32];
    end
    return res;
  endfunction

  ////////////////////////////////////////
  // compare process
  ////////////////////////////////////////

  // result checked on the ack rise and must then hold while ack_o stays high
  always @(negedge clk_i) begin
    if (ack_o && !ack_seen) begin
      assert (n_sent > 0) else stop_on_error("ack_o rose without any request");
      assert (result_o === exp_result) else report_mismatch(test_name, exp_result, result_o);
      held_result = result_o;
      n_checked++;
    end else if (ack_o && ack_seen) begin
      assert (result_o === held_result)
        else report_mismatch({test_name, " held"}, held_result, result_o);
    end
    ack_seen = ack_o;
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  // one four-phase transaction with req_i held for extra cycles after ack_o
  task automatic run_request(input string name, input md_op_e op, input logic sa,
                             input logic sb, input logic vec, input vsew_e vsew,
                             input logic [31:0] a, input logic [31:0] b,
                             input int hold_cycles);
    int cnt;
    @(posedge clk_i);
    #1;
    op_i       = op;
    signed_a_i = sa;
    signed_b_i = sb;
    vec_i      = vec;
    vsew_i     = vsew;
    op_a_i     = a;
    op_b_i     = b;
    exp_result = expected_product(op, sa, sb, vec, vsew, a, b);
    test_name  = name;
    n_sent++;
    req_i      = 1'b1;
    cnt = 0;
    while (!ack_o) begin
      @(posedge clk_i);
      #1;
      cnt++;
      if (cnt > TIMEOUT_CYCLES) stop_on_error({"timeout waiting for ack_o in ", name});
    end
    for (int i = 0; i < hold_cycles; i++) begin
      @(posedge clk_i);
      #1;
      assert (ack_o) else stop_on_error({"ack_o dropped while req_i held in ", name});
    end
    req_i = 1'b0;
    cnt = 0;
    while (ack_o) begin
      @(posedge clk_i);
      #1;
      cnt++;
      if (cnt > TIMEOUT_CYCLES) stop_on_error({"timeout waiting for ack_o to fall in ", name});
    end
    assert (cnt == 1) else stop_on_error({"ack_o did not fall one cycle after req_i in ", name});
  endtask

  initial begin
    clk_i      = 1'b0;
    rst_ni     = 1'b0;
    req_i      = 1'b0;
    op_i       = MD_OP_MULL;
    signed_a_i = 1'b0;
    signed_b_i = 1'b0;
    vec_i      = 1'b0;
    vsew_i     = VSEW_32;
    op_a_i     = '0;
    op_b_i     = '0;
    exp_result = '0;
    held_result = '0;
    test_name  = "reset";
    n_sent     = 0;
    n_checked  = 0;
    ack_seen   = 1'b0;
    seed       = 32'hbf0fdda9;
    corners[0] = 32'h8000_0000;
    corners[1] = 32'hffff_ffff;
    corners[2] = 32'h7fff_ffff;
    corners[3] = 32'h0000_0001;

    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // no ack without a request
    for (int i = 0; i < 4; i++) begin
      @(posedge clk_i);
      #1;
      assert (!ack_o) else stop_on_error("ack_o high after reset with no request");
    end

    // scalar MULL
    run_request("mull_zero", MD_OP_MULL, 1'b1, 1'b1, 1'b0, VSEW_32, 32'h0, 32'h0, 0);
    run_request("mull_corner", MD_OP_MULL, 1'b1, 1'b1, 1'b0, VSEW_32, 32'hffff_ffff,
                32'hffff_ffff, 0);
    run_request("mull_corner", MD_OP_MULL, 1'b0, 1'b0, 1'b0, VSEW_32, 32'h8000_0000,
                32'h8000_0000, 0);
    run_request("mull_corner", MD_OP_MULL, 1'b1, 1'b1, 1'b0, VSEW_32, 32'h1234_5678,
                32'h9abc_def0, 0);
    for (int i = 0; i < 20; i++) begin
      run_request("mull_rand", MD_OP_MULL, 1'b1, 1'b1, 1'b0, VSEW_32, $random(seed),
                  $random(seed), 0);
    end

    // MULH, MULHSU, MULHU and the unsigned-a variant over corners and random words
    for (int s = 0; s < 4; s++) begin
      for (int i = 0; i < 4; i++) begin
        for (int j = 0; j < 4; j++) begin
          run_request("mulh_corner", MD_OP_MULH, s[1], s[0], 1'b0, VSEW_32, corners[i],
                      corners[j], 0);
        end
      end
      for (int i = 0; i < 10; i++) begin
        run_request("mulh_rand", MD_OP_MULH, s[1], s[0], 1'b0, VSEW_32, $random(seed),
                    $random(seed), 0);
      end
    end

    // vector lanes
    run_request("vec8_corner", MD_OP_MULL, 1'b0, 1'b0, 1'b1, VSEW_8, 32'h80ff_7f01,
                32'hff80_017f, 0);
    for (int i = 0; i < 10; i++) begin
      run_request("vec8_rand", MD_OP_MULL, 1'b0, 1'b0, 1'b1, VSEW_8, $random(seed),
                  $random(seed), 0);
      run_request("vec16_rand", MD_OP_MULL, 1'b0, 1'b0, 1'b1, VSEW_16, $random(seed),
                  $random(seed), 0);
      run_request("vec32_rand", MD_OP_MULH, 1'b1, 1'b1, 1'b1, VSEW_32, $random(seed),
                  $random(seed), 0);
    end

    // back-pressure with req_i held after ack_o
    run_request("hold_mulh", MD_OP_MULH, 1'b1, 1'b0, 1'b0, VSEW_32, 32'h8000_0000,
                32'hffff_ffff, 5);
    run_request("hold_vec8", MD_OP_MULL, 1'b0, 1'b0, 1'b1, VSEW_8, $random(seed),
                $random(seed), 4);

    // back-to-back mixed requests
    for (int i = 0; i < 30; i++) begin
      r = $random(seed);
      rnd_op = r[0] ? MD_OP_MULH : MD_OP_MULL;
      case (r[5:4])
        2'd0:    rnd_vsew = VSEW_8;
        2'd1:    rnd_vsew = VSEW_16;
        default: rnd_vsew = VSEW_32;
      endcase
      run_request("mixed_rand", rnd_op, r[1], r[2], r[3], rnd_vsew, $random(seed),
                  $random(seed), int'(r[7:6]));
    end

    @(posedge clk_i);
    #1;
    if (n_sent > 0 && n_checked == n_sent) begin
      $display("TEST OK");
      $finish;
    end else begin
      stop_on_error($sformatf("only %0d of %0d results were checked", n_checked, n_sent));
    end
  end

endmodule
